// File: compare_lane.sv
// Compare lane. Produces the six compare flags over the 66 data bits and a
// packed signed less-than mask per half, both one cycle after valid_in.
module compare_lane (
  input  logic             clk,
  input  logic             rst,
  input  logic             valid_in,
  input  fpsu_pkg::word_t  a,
  input  fpsu_pkg::word_t  b,
  output fpsu_pkg::word_t  result,
  output logic             result_valid,
  output fpsu_pkg::flags_t flags,
  output logic             flags_valid
);
  import fpsu_pkg::*;

  logic [DATA_W-1:0] a_data;
  logic [DATA_W-1:0] b_data;
  flags_t flg;
  half_t  mask_hi, mask_lo;
  logic   valid_q;

  assign a_data = a[DATA_W-1:0];
  assign b_data = b[DATA_W-1:0];

  always_comb begin
    flg          = '0;
    flg[FLG_EQ]  = a_data == b_data;
    flg[FLG_LTS] = $signed(a_data) < $signed(b_data);
    flg[FLG_LTU] = a_data < b_data;
    flg[FLG_GTS] = $signed(a_data) > $signed(b_data);
    flg[FLG_GTU] = a_data > b_data;
    flg[FLG_AZ]  = a_data == '0;
  end

  // all ones where a half is signed-less than b half
  assign mask_hi = {HALF_W{$signed(a[DATA_W-1:HALF_W]) < $signed(b[DATA_W-1:HALF_W])}};
  assign mask_lo = {HALF_W{$signed(a[HALF_W-1:0]) < $signed(b[HALF_W-1:0])}};

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    result <= {TAG_INT, mask_hi, mask_lo};
    flags  <= flg;
  end

  assign result_valid = valid_q;
  assign flags_valid  = valid_q;

endmodule

// File: fpsu_pkg.sv
// Shared widths, word types, function codes and the operation-class enum
// for the SIMD execution unit. Imported by every RTL module and the testbench.
package fpsu_pkg;

  localparam int WORD_W  = 68;
  localparam int HALF_W  = 33;
  localparam int TAG_W   = 2;
  localparam int DATA_W  = 2 * HALF_W;  // both packed halves, tag excluded
  localparam int NUM_BUS = 4;
  localparam int OP_W    = 13;
  localparam int FN_W    = 8;
  localparam int FLAG_W  = 6;

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [HALF_W-1:0]  half_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [OP_W-1:0]    opcode_t;
  typedef logic [FN_W-1:0]    fn_t;
  typedef logic [NUM_BUS-1:0] fwd_t;
  typedef logic [FLAG_W-1:0]  flags_t;

  localparam tag_t TAG_INT = 2'd1;

  // modifier bit positions in the opcode
  localparam int OP_MERGE_A = 8;
  localparam int OP_SWAP    = 9;
  localparam int OP_DUP     = 10;
  localparam int OP_REVERSE = 12;

  // logic group, low two bits pick the operation
  localparam fn_t FN_LOGIC = 8'h04;
  localparam fn_t FN_AND   = 8'h04;
  localparam fn_t FN_OR    = 8'h05;
  localparam fn_t FN_XOR   = 8'h06;
  localparam fn_t FN_ANDN  = 8'h07;
  localparam fn_t FN_ADD   = 8'h10;
  localparam fn_t FN_SUB   = 8'h11;
  localparam fn_t FN_PERM  = 8'h20;
  localparam fn_t FN_CMP   = 8'h30;

  // compare flag bit positions
  localparam int FLG_EQ  = 0;
  localparam int FLG_LTS = 1;
  localparam int FLG_LTU = 2;
  localparam int FLG_GTS = 3;
  localparam int FLG_GTU = 4;
  localparam int FLG_AZ  = 5;

  typedef enum logic [2:0] {
    CL_NONE,
    CL_LOGIC,
    CL_ADD,
    CL_SUB,
    CL_PERM,
    CL_CMP
  } op_class_t;

endpackage

// File: op_decode.sv
// Issue stage decode. Registers the strobe and opcode and turns the function
// code into a lane class plus the modifier bits the packed lane needs.
// valid covers the packed lane classes, cmp_valid the compare lane.
module op_decode (
  input  logic                clk,
  input  logic                rst,
  input  logic                en,
  input  fpsu_pkg::opcode_t   op,
  output logic                valid,
  output logic                cmp_valid,
  output fpsu_pkg::op_class_t op_class,
  output logic [1:0]          logic_sel,
  output logic                merge_a,
  output logic                swap,
  output logic                dup,
  output logic                reverse
);
  import fpsu_pkg::*;

  fn_t       fn;
  op_class_t dec_class;

  assign fn = op[FN_W-1:0];

  always_comb begin
    dec_class = CL_NONE;
    if (fn[FN_W-1:2] == FN_LOGIC[FN_W-1:2]) begin
      dec_class = CL_LOGIC;
    end else begin
      case (fn)
        FN_ADD:  dec_class = CL_ADD;
        FN_SUB:  dec_class = CL_SUB;
        FN_PERM: dec_class = CL_PERM;
        FN_CMP:  dec_class = CL_CMP;
        default: dec_class = CL_NONE;  // unknown code, no result
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid     <= 1'b0;
      cmp_valid <= 1'b0;
      op_class  <= CL_NONE;
    end else begin
      valid     <= en && dec_class != CL_NONE && dec_class != CL_CMP;
      cmp_valid <= en && dec_class == CL_CMP;
      op_class  <= dec_class;
    end
  end

  always_ff @(posedge clk) begin
    logic_sel <= fn[1:0];
    merge_a   <= op[OP_MERGE_A];
    swap      <= op[OP_SWAP];
    dup       <= op[OP_DUP];
    reverse   <= op[OP_REVERSE];
  end

endmodule

// File: operand_forward.sv
// Source operand select for one operand of the SIMD unit.
// Picks the port value, a result bus of this cycle or a result bus of the
// cycle before, and registers the choice for the execution lanes.
module operand_forward (
  input  logic            clk,
  input  logic            rst,
  input  fpsu_pkg::word_t port_op,
  input  fpsu_pkg::fwd_t  fwd_now,
  input  fpsu_pkg::fwd_t  fwd_late,
  input  fpsu_pkg::word_t bus0,
  input  fpsu_pkg::word_t bus1,
  input  fpsu_pkg::word_t bus2,
  input  fpsu_pkg::word_t bus3,
  output fpsu_pkg::word_t operand
);
  import fpsu_pkg::*;

  word_t bus_now [NUM_BUS];
  word_t bus_q   [NUM_BUS];  // bus values one cycle back
  word_t sel;

  always_comb begin
    bus_now[0] = bus0;
    bus_now[1] = bus1;
    bus_now[2] = bus2;
    bus_now[3] = bus3;
  end

  always_ff @(posedge clk) begin
    bus_q <= bus_now;
  end

  // current-cycle select wins over late select
  always_comb begin
    sel = port_op;
    for (int k = 0; k < NUM_BUS; k++) begin
      if (fwd_late[k]) sel = bus_q[k];
    end
    for (int k = 0; k < NUM_BUS; k++) begin
      if (fwd_now[k]) sel = bus_now[k];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      operand <= '0;
    end else begin
      operand <= sel;  // loads every cycle, en ignored
    end
  end

endmodule

// File: simd_fpsu.f
fpsu_pkg.sv
operand_forward.sv
op_decode.sv
simd_lane.sv
compare_lane.sv
wb_arbiter.sv
simd_fpsu.sv
simd_fpsu_tb.sv

// File: simd_fpsu.sv
// Top of the SIMD execution unit: operand forwarding, decode, the packed and
// compare lanes, and the shared write-back arbiter. Results reach wb_data
// three cycles after issue, compare flags two cycles after issue.
module simd_fpsu (
  input  logic              clk,
  input  logic              rst,
  input  logic              en,
  input  fpsu_pkg::opcode_t op,
  input  fpsu_pkg::word_t   a,
  input  fpsu_pkg::word_t   b,
  input  fpsu_pkg::fwd_t    fwd_now_a,
  input  fpsu_pkg::fwd_t    fwd_late_a,
  input  fpsu_pkg::fwd_t    fwd_now_b,
  input  fpsu_pkg::fwd_t    fwd_late_b,
  input  fpsu_pkg::word_t   res_bus0,
  input  fpsu_pkg::word_t   res_bus1,
  input  fpsu_pkg::word_t   res_bus2,
  input  fpsu_pkg::word_t   res_bus3,
  input  logic [1:0]        alt_sel,
  input  fpsu_pkg::word_t   alt_data0,
  input  fpsu_pkg::word_t   alt_data1,
  output fpsu_pkg::word_t   wb_data,
  output logic              wb_valid,
  output fpsu_pkg::flags_t  flags,
  output logic              flags_valid
);
  import fpsu_pkg::*;

  word_t     opa, opb;
  logic      dec_valid, dec_cmp_valid;
  op_class_t dec_class;
  logic [1:0] dec_logic_sel;
  logic      dec_merge_a, dec_swap, dec_dup, dec_reverse;
  word_t     simd_result, cmp_result;
  logic      simd_valid, cmp_valid;

  operand_forward fwd_a (
    .clk(clk), .rst(rst), .port_op(a), .fwd_now(fwd_now_a), .fwd_late(fwd_late_a),
    .bus0(res_bus0), .bus1(res_bus1), .bus2(res_bus2), .bus3(res_bus3), .operand(opa)
  );

  operand_forward fwd_b (
    .clk(clk), .rst(rst), .port_op(b), .fwd_now(fwd_now_b), .fwd_late(fwd_late_b),
    .bus0(res_bus0), .bus1(res_bus1), .bus2(res_bus2), .bus3(res_bus3), .operand(opb)
  );

  op_decode decode (
    .clk(clk), .rst(rst), .en(en), .op(op), .valid(dec_valid), .cmp_valid(dec_cmp_valid),
    .op_class(dec_class), .logic_sel(dec_logic_sel), .merge_a(dec_merge_a),
    .swap(dec_swap), .dup(dec_dup), .reverse(dec_reverse)
  );

  simd_lane lane (
    .clk(clk), .rst(rst), .valid_in(dec_valid), .op_class(dec_class),
    .logic_sel(dec_logic_sel), .merge_a(dec_merge_a), .swap(dec_swap), .dup(dec_dup),
    .reverse(dec_reverse), .a(opa), .b(opb), .result(simd_result), .result_valid(simd_valid)
  );

  compare_lane cmp (
    .clk(clk), .rst(rst), .valid_in(dec_cmp_valid), .a(opa), .b(opb),
    .result(cmp_result), .result_valid(cmp_valid), .flags(flags), .flags_valid(flags_valid)
  );

  wb_arbiter arb (
    .clk(clk), .rst(rst), .alt_sel(alt_sel), .alt_data0(alt_data0), .alt_data1(alt_data1),
    .lane0_result(simd_result), .lane1_result(cmp_result),
    .lane0_valid(simd_valid), .lane1_valid(cmp_valid),
    .wb_data(wb_data), .wb_valid(wb_valid)
  );

endmodule

// File: simd_fpsu_tb.sv
// Random testbench for the SIMD execution unit. Drives seeded random issue,
// forwarding, result bus and alternate write-back traffic, and checks
// wb_data and flags against a cycle model of forwarding, lanes and arbiter.
module simd_fpsu_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fpsu_pkg::*;

  localparam int RST_CYC  = 16;
  localparam int IDLE_CYC = 4;      // quiet start after reset
  localparam int N_CYC    = 2000;
  localparam int DRAIN    = 4;
  localparam int N_TOT    = N_CYC + DRAIN;
  localparam int MAX_CYC  = N_CYC + N_CYC / 20;  // run length plus five percent

  logic clk, rst, en;
  opcode_t op;
  word_t a, b, res_bus0, res_bus1, res_bus2, res_bus3, alt_data0, alt_data1;
  fwd_t fwd_now_a, fwd_late_a, fwd_now_b, fwd_late_b;
  logic [1:0] alt_sel;
  word_t wb_data;
  logic wb_valid, flags_valid;
  flags_t flags;

  // model history per cycle after reset
  word_t bus_cur [NUM_BUS];
  word_t bus_prev [NUM_BUS];
  logic [1:0] alt_sel_h [N_TOT];
  word_t alt0_h [N_TOT];
  word_t alt1_h [N_TOT];
  logic lane_v_h [N_TOT];
  word_t lane_r_h [N_TOT];
  logic flag_v_h [N_TOT];
  flags_t flag_h [N_TOT];
  int cyc_cnt = 0;

  simd_fpsu dut0 (
    .clk(clk), .rst(rst), .en(en), .op(op), .a(a), .b(b),
    .fwd_now_a(fwd_now_a), .fwd_late_a(fwd_late_a),
    .fwd_now_b(fwd_now_b), .fwd_late_b(fwd_late_b),
    .res_bus0(res_bus0), .res_bus1(res_bus1), .res_bus2(res_bus2), .res_bus3(res_bus3),
    .alt_sel(alt_sel), .alt_data0(alt_data0), .alt_data1(alt_data1),
    .wb_data(wb_data), .wb_valid(wb_valid), .flags(flags), .flags_valid(flags_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= MAX_CYC) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYC);
      $display("sim failed");
      $fatal(1);
    end
  end

  function automatic word_t rand_word();
    logic [95:0] r;
    r = {$urandom, $urandom, $urandom};
    return r[WORD_W-1:0];
  endfunction

  function automatic opcode_t rand_opcode();
    fn_t fn;
    opcode_t opc;
    case ($urandom_range(9, 0))
      0: fn = FN_AND;
      1: fn = FN_OR;
      2: fn = FN_XOR;
      3: fn = FN_ANDN;
      4: fn = FN_ADD;
      5: fn = FN_SUB;
      6: fn = FN_PERM;
      7: fn = FN_CMP;
      default: fn = fn_t'($urandom_range(255, 0));  // mostly unknown codes
    endcase
    opc = opcode_t'($urandom_range(8191, 0));
    opc[FN_W-1:0] = fn;
    return opc;
  endfunction

  task automatic pick_fwd(output fwd_t now_s, output fwd_t late_s);
    int pick;
    pick = $urandom_range(11, 0);
    now_s = '0;
    late_s = '0;
    if (pick < 4) now_s[pick] = 1'b1;
    else if (pick < 8) late_s[pick-4] = 1'b1;
  endtask

  function automatic word_t fwd_model(word_t port, fwd_t now_s, fwd_t late_s);
    word_t v;
    v = port;
    for (int k = 0; k < NUM_BUS; k++) begin
      if (now_s[k]) v = bus_cur[k];
      else if (late_s[k]) v = bus_prev[k];
    end
    return v;
  endfunction

  function automatic op_class_t class_of(fn_t fn);
    if ((fn & ~fn_t'(3)) == FN_LOGIC) return CL_LOGIC;
    if (fn == FN_ADD) return CL_ADD;
    if (fn == FN_SUB) return CL_SUB;
    if (fn == FN_PERM) return CL_PERM;
    if (fn == FN_CMP) return CL_CMP;
    return CL_NONE;
  endfunction

  function automatic word_t simd_model(op_class_t cls, opcode_t opc, word_t x, word_t y);
    logic [DATA_W-1:0] xd, yd, rd;
    half_t xh, xl, yh, yl, rh, rl, tmp;
    xd = x[DATA_W-1:0];
    yd = y[DATA_W-1:0];
    xh = xd[DATA_W-1:HALF_W];
    xl = xd[HALF_W-1:0];
    yh = yd[DATA_W-1:HALF_W];
    yl = yd[HALF_W-1:0];
    rd = '0;
    case (cls)
      CL_LOGIC: begin
        if (opc[1:0] == 2'd0) rd = xd & yd;
        else if (opc[1:0] == 2'd1) rd = xd | yd;
        else if (opc[1:0] == 2'd2) rd = xd ^ yd;
        else rd = xd & ~yd;
      end
      CL_ADD: begin
        rh = xh + yh;
        rl = xl + yl;
        rd = {rh, rl};
      end
      CL_SUB: begin
        rh = opc[OP_REVERSE] ? yh - xh : xh - yh;
        rl = opc[OP_REVERSE] ? yl - xl : xl - yl;
        rd = {rh, rl};
      end
      CL_PERM: begin
        rh = opc[OP_MERGE_A] ? xh : yh;
        rl = xl;
        if (opc[OP_SWAP]) begin
          tmp = rh;
          rh = rl;
          rl = tmp;
        end
        if (opc[OP_DUP]) rh = rl;
        rd = {rh, rl};
      end
      default: rd = '0;
    endcase
    return {x[WORD_W-1:DATA_W], rd};
  endfunction

  function automatic flags_t flags_model(word_t x, word_t y);
    logic [DATA_W-1:0] xd, yd, xs, ys, sgn;
    flags_t f;
    sgn = '0;
    sgn[DATA_W-1] = 1'b1;
    xd = x[DATA_W-1:0];
    yd = y[DATA_W-1:0];
    xs = xd ^ sgn;  // offset binary keeps signed order
    ys = yd ^ sgn;
    f = '0;
    f[FLG_EQ]  = xd == yd;
    f[FLG_LTS] = xs < ys;
    f[FLG_LTU] = xd < yd;
    f[FLG_GTS] = xs > ys;
    f[FLG_GTU] = xd > yd;
    f[FLG_AZ]  = xd == '0;
    return f;
  endfunction

  function automatic word_t mask_model(word_t x, word_t y);
    half_t hs, mh, ml;
    hs = '0;
    hs[HALF_W-1] = 1'b1;
    mh = '0;
    ml = '0;
    if ((x[DATA_W-1:HALF_W] ^ hs) < (y[DATA_W-1:HALF_W] ^ hs)) mh = '1;
    if ((x[HALF_W-1:0] ^ hs) < (y[HALF_W-1:0] ^ hs)) ml = '1;
    return {TAG_INT, mh, ml};
  endfunction

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    $display("mismatch %s: got %0h expected %0h", name, got, exp);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic got_v, input logic exp_v,
                            input word_t got, input word_t exp);
    if (got_v !== exp_v) report_mismatch({name, " valid"}, word_t'(got_v), word_t'(exp_v));
    else if (exp_v && got !== exp) report_mismatch(name, got, exp);
  endtask

  task automatic check_flags(input string name, input logic got_v, input logic exp_v,
                             input flags_t got, input flags_t exp);
    if (got_v !== exp_v) report_mismatch({name, " valid"}, word_t'(got_v), word_t'(exp_v));
    else if (exp_v && got !== exp) report_mismatch(name, word_t'(got), word_t'(exp));
  endtask

  task automatic drive_inputs(input int t, input logic active);
    word_t va, vb, xa, xb, d0, d1;
    fwd_t na, la, nb, lb;
    opcode_t opc;
    logic issue;
    logic [1:0] asel;
    op_class_t cls;
    for (int k = 0; k < NUM_BUS; k++) begin
      bus_prev[k] = bus_cur[k];
      bus_cur[k] = rand_word();
    end
    va = rand_word();
    if ($urandom_range(15, 0) == 0) va[DATA_W-1:0] = '0;
    vb = ($urandom_range(7, 0) == 0) ? va : rand_word();
    opc = rand_opcode();
    pick_fwd(na, la);
    pick_fwd(nb, lb);
    d0 = rand_word();
    d1 = rand_word();
    issue = active && $urandom_range(3, 0) != 0;
    asel = 2'b00;
    if (active) begin
      case ($urandom_range(7, 0))
        0: asel = 2'b01;
        1: asel = 2'b10;
        2: asel = 2'b11;
        default: asel = 2'b00;
      endcase
    end
    en <= issue;
    op <= opc;
    a <= va;
    b <= vb;
    fwd_now_a <= na;
    fwd_late_a <= la;
    fwd_now_b <= nb;
    fwd_late_b <= lb;
    res_bus0 <= bus_cur[0];
    res_bus1 <= bus_cur[1];
    res_bus2 <= bus_cur[2];
    res_bus3 <= bus_cur[3];
    alt_sel <= asel;
    alt_data0 <= d0;
    alt_data1 <= d1;
    xa = fwd_model(va, na, la);
    xb = fwd_model(vb, nb, lb);
    cls = class_of(opc[FN_W-1:0]);
    alt_sel_h[t] = asel;
    alt0_h[t] = d0;
    alt1_h[t] = d1;
    lane_v_h[t] = issue && cls != CL_NONE;
    flag_v_h[t] = issue && cls == CL_CMP;
    flag_h[t] = flags_model(xa, xb);
    if (cls == CL_CMP) lane_r_h[t] = mask_model(xa, xb);
    else lane_r_h[t] = simd_model(cls, opc, xa, xb);
  endtask

  task automatic check_outputs(input int c);
    logic exp_v, exp_fv;
    word_t exp_d;
    flags_t exp_f;
    exp_v = 1'b0;
    exp_d = '0;
    exp_fv = 1'b0;
    exp_f = '0;
    if (c >= 3 && lane_v_h[c-3]) begin
      exp_v = 1'b1;
      exp_d = lane_r_h[c-3];
    end
    if (c >= 1 && alt_sel_h[c-1] != 2'b00) begin  // alternates override the lane
      exp_v = 1'b1;
      exp_d = alt_sel_h[c-1][1] ? alt1_h[c-1] : alt0_h[c-1];
    end
    if (c >= 2) begin
      exp_fv = flag_v_h[c-2];
      exp_f = flag_h[c-2];
    end
    check_flags("flags", flags_valid, exp_fv, flags, exp_f);
    check_word("wb_data", wb_valid, exp_v, wb_data, exp_d);
  endtask

  initial begin
    void'($urandom(50));
    rst = 1'b1;
    en = 1'b0;
    op = '0;
    a = '0;
    b = '0;
    fwd_now_a = '0;
    fwd_late_a = '0;
    fwd_now_b = '0;
    fwd_late_b = '0;
    res_bus0 = '0;
    res_bus1 = '0;
    res_bus2 = '0;
    res_bus3 = '0;
    alt_sel = 2'b00;
    alt_data0 = '0;
    alt_data1 = '0;
    for (int k = 0; k < NUM_BUS; k++) begin
      bus_cur[k] = '0;
      bus_prev[k] = '0;
    end
    repeat (RST_CYC) @(posedge clk);
    rst <= 1'b0;
    for (int t = 0; t < N_TOT; t++) begin
      drive_inputs(t, t >= IDLE_CYC && t < N_CYC);
      @(negedge clk);
      check_outputs(t);
      @(posedge clk);
    end
    $display("sim passed");
    $finish;
  end

endmodule

// File: simd_lane.sv
// Packed execution lane for bitwise logic on the data bits, per-half add and
// subtract with 33-bit wrap, and half permutes. One cycle of latency, with the
// result tagged by the tag of operand a.
module simd_lane (
  input  logic                clk,
  input  logic                rst,
  input  logic                valid_in,
  input  fpsu_pkg::op_class_t op_class,
  input  logic [1:0]          logic_sel,
  input  logic                merge_a,
  input  logic                swap,
  input  logic                dup,
  input  logic                reverse,
  input  fpsu_pkg::word_t     a,
  input  fpsu_pkg::word_t     b,
  output fpsu_pkg::word_t     result,
  output logic                result_valid
);
  import fpsu_pkg::*;

  logic [DATA_W-1:0] a_data;
  logic [DATA_W-1:0] b_data;
  logic [DATA_W-1:0] res_data;
  half_t a_hi, a_lo, b_hi, b_lo;
  half_t p_hi, p_lo;

  assign a_data = a[DATA_W-1:0];
  assign b_data = b[DATA_W-1:0];
  assign a_hi   = a[DATA_W-1:HALF_W];
  assign a_lo   = a[HALF_W-1:0];
  assign b_hi   = b[DATA_W-1:HALF_W];
  assign b_lo   = b[HALF_W-1:0];

  // permute picks the halves, swaps them, then copies low up
  always_comb begin
    p_hi = merge_a ? a_hi : b_hi;
    p_lo = a_lo;
    if (swap) begin
      p_hi = a_lo;
      p_lo = merge_a ? a_hi : b_hi;
    end
    if (dup) p_hi = p_lo;
  end

  always_comb begin
    res_data = '0;
    case (op_class)
      CL_LOGIC: begin
        case (logic_sel)
          2'd0:    res_data = a_data & b_data;
          2'd1:    res_data = a_data | b_data;
          2'd2:    res_data = a_data ^ b_data;
          default: res_data = a_data & ~b_data;
        endcase
      end
      CL_ADD:  res_data = {half_t'(a_hi + b_hi), half_t'(a_lo + b_lo)};
      CL_SUB: begin
        if (reverse) res_data = {half_t'(b_hi - a_hi), half_t'(b_lo - a_lo)};
        else         res_data = {half_t'(a_hi - b_hi), half_t'(a_lo - b_lo)};
      end
      CL_PERM: res_data = {p_hi, p_lo};
      default: res_data = '0;  // compare and none carry no packed result
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    result <= {a[WORD_W-1:DATA_W], res_data};
  end

endmodule

// File: wb_arbiter.sv
// Write-back bus arbiter. Alternate data 1 beats alternate data 0, which
// beats the lane results; a losing lane result is dropped. Registered output.
module wb_arbiter (
  input  logic            clk,
  input  logic            rst,
  input  logic [1:0]      alt_sel,
  input  fpsu_pkg::word_t alt_data0,
  input  fpsu_pkg::word_t alt_data1,
  input  fpsu_pkg::word_t lane0_result,
  input  fpsu_pkg::word_t lane1_result,
  input  logic            lane0_valid,
  input  logic            lane1_valid,
  output fpsu_pkg::word_t wb_data,
  output logic            wb_valid
);
  import fpsu_pkg::*;

  word_t win;

  always_comb begin
    if (alt_sel[1])       win = alt_data1;
    else if (alt_sel[0])  win = alt_data0;
    else if (lane0_valid) win = lane0_result;
    else                  win = lane1_result;  // lanes never both valid
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= |alt_sel || lane0_valid || lane1_valid;
    end
  end

  always_ff @(posedge clk) begin
    wb_data <= win;
  end

endmodule
